// ==== all.f ====
hdl/mipsPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/regFile.sv
hdl/executeStage.sv
hdl/memWbStage.sv
hdl/mipsCore.sv
verif/tbClock.sv
verif/tbMipsCore.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbMipsCore -f all.f -o simMipsCore

./obj_dir/simMipsCore > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
  exit 1
fi

// ==== verif/tbMipsCore.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbMipsCore;
  import mipsPkg::*;

  localparam int AddrWidth = 11;
  localparam int StepLimit = 5000;  // Interpreter safety bound

  wire                 CLK;
  wire                 RST_X;
  logic                STALL;
  logic                restart;
  wire [AddrWidth-1:0] I_ADDR;
  wordT                I_IN;
  wordT                D_ADDR;
  wordT                D_IN;
  wordT                D_OUT;
  wire                 D_OE;
  wire [3:0]           D_WE;

  wordT  imem [0:511];     // Word addressed program
  wordT  dmem [0:255];
  int    progLen;
  wordT  expAddr [$];      // Expected stores in order
  wordT  expData [$];
  int    seen;             // Stores observed this test
  bit    checking;
  string testName;
  int    testErrors;
  int    passCount;
  int    failCount;
  int    seed = 77795;
  int    activeCycles;     // Cycles with STALL low
  int    cycleLimit;

  tbClock #(.ResetCycles(4)) clockGen (.restart(restart), .CLK(CLK), .RST_X(RST_X));

  mipsCore #(.AddrWidth(AddrWidth)) mipsCore_inst (
    .CLK(CLK), .RST_X(RST_X), .STALL(STALL), .I_ADDR(I_ADDR), .I_IN(I_IN),
    .D_ADDR(D_ADDR), .D_IN(D_IN), .D_OUT(D_OUT), .D_OE(D_OE), .D_WE(D_WE)
  );

  assign I_IN = imem[I_ADDR[10:2]];  // Combinational fetch

  // Pattern over the whole word index
  function automatic wordT fillWord(input int idx);
    return 32'hC0DE0000 ^ (idx * 32'h00010003);
  endfunction

  // Data memory, read data lands one cycle after D_OE
  always begin : dataMemory
    logic oeS;
    logic weS;
    wordT addrS;
    wordT outS;
    @(posedge CLK);
    oeS   = D_OE;
    weS   = RST_X && (D_WE == 4'b1111);
    addrS = D_ADDR;
    outS  = D_OUT;
    #1;
    if (weS) dmem[addrS[9:2]] = outS;
    if (oeS) D_IN = dmem[addrS[9:2]];  // Held otherwise, also during STALL
  end

  // Store compare process
  always @(posedge CLK) begin
    if (checking && RST_X && D_WE == 4'b1111) begin
      if (seen >= expAddr.size()) begin
        $display("test %s: extra store of %h to %h after all %0d expected stores",
                 testName, D_OUT, D_ADDR, expAddr.size());
        testErrors++;
      end else if (D_ADDR !== expAddr[seen] || D_OUT !== expData[seen]) begin
        $display("Mismatch test %s store %0d: expected %h <- %h, actual %h <- %h",
                 testName, seen, expAddr[seen], expData[seen], D_ADDR, D_OUT);
        testErrors++;
      end
      seen++;
    end
  end

  // Watchdog on unstalled cycles
  always @(posedge CLK) begin
    if (!STALL) activeCycles++;
    if (activeCycles > cycleLimit) begin
      $display("test %s: timed out after %0d cycles with %0d of %0d stores seen",
               testName, activeCycles, seen, expAddr.size());
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ISA-level model, no delay slot
  function automatic int interpret();
    wordT   regs [0:31];
    wordT   refMem [0:255];
    wordT   inst;
    wordT   a;
    wordT   b;
    wordT   imm;
    wordT   addr;
    wordT   val;
    regIdxT dest;
    int     pc;
    int     nextPc;
    int     steps;
    bit     done;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < 256; i++) refMem[i] = fillWord(i);
    expAddr.delete();
    expData.delete();
    pc    = 0;
    steps = 0;
    done  = 0;
    while (!done && steps < StepLimit) begin
      inst   = imem[(pc / 4) % 512];
      a      = regs[inst[25:21]];
      b      = regs[inst[20:16]];
      imm    = {{16{inst[15]}}, inst[15:0]};
      addr   = a + imm;
      nextPc = pc + 4;
      dest   = '0;
      val    = '0;
      steps++;
      case (inst[31:26])
        opSpecial: begin
          dest = inst[15:11];
          case (inst[5:0])
            fnAdd:   val = a + b;
            fnSllv:  val = a << b[4:0];  // rs shifted by rt
            fnSrlv:  val = a >> b[4:0];
            default: dest = '0;
          endcase
        end
        opAddi: begin
          dest = inst[20:16];
          val  = a + imm;
        end
        opLw: begin
          dest = inst[20:16];
          val  = refMem[addr[9:2]];
        end
        opSw: begin
          refMem[addr[9:2]] = b;
          expAddr.push_back(addr);
          expData.push_back(b);
        end
        opBeq, opBne: begin
          if ((inst[31:26] == opBeq) == (a == b)) begin
            nextPc = pc + 4 + 4 * int'($signed(imm));
            if (nextPc == pc) done = 1;  // Self-branch ends program
          end
        end
        default: dest = '0;
      endcase
      if (dest != '0) regs[dest] = val;
      pc = nextPc & ((1 << AddrWidth) - 1);
    end
    return steps;
  endfunction

  function automatic wordT encodeI(input opcodeE op, input regIdxT rt, input regIdxT rs,
                                   input int imm);
    return {op, rs, rt, imm[15:0]};
  endfunction

  function automatic wordT encodeB(input opcodeE op, input regIdxT rs, input regIdxT rt,
                                   input int off);
    return {op, rs, rt, off[15:0]};  // Offset in words from pc+4
  endfunction

  function automatic wordT encodeR(input functE fn, input regIdxT rd, input regIdxT rs,
                                   input regIdxT rt);
    return {opSpecial, rs, rt, rd, 5'd0, fn};
  endfunction

  task automatic clearProgram();
    for (int i = 0; i < 512; i++) imem[i] = '0;
    progLen = 0;
  endtask

  task automatic putInst(input wordT w);
    imem[progLen] = w;
    progLen++;
  endtask

  task automatic buildForwardProgram();
    clearProgram();
    putInst(encodeI(opAddi, 1, 0, 5));
    putInst(encodeI(opAddi, 2, 1, 7));     // EX/MEM bypass
    putInst(encodeR(fnAdd, 3, 1, 2));      // Both paths
    putInst(encodeR(fnAdd, 3, 3, 3));
    putInst(encodeI(opAddi, 0, 3, 9));     // r0 stays zero
    putInst(encodeR(fnAdd, 4, 0, 3));
    putInst(encodeI(opAddi, 5, 0, 'h100));
    putInst(encodeI(opSw, 3, 5, 0));
    putInst(encodeI(opSw, 4, 5, 4));
    putInst(encodeR(fnAdd, 6, 4, 1));
    putInst(encodeI(opSw, 6, 5, 8));       // Store data forwarded
    putInst(encodeI(opAddi, 7, 6, -40));
    putInst(encodeI(opSw, 7, 5, 12));
    putInst(encodeI(opSw, 0, 5, 16));
    putInst(encodeB(opBeq, 0, 0, -1));
  endtask

  task automatic buildShiftProgram();
    clearProgram();
    putInst(encodeI(opAddi, 1, 0, 'h1234));
    putInst(encodeI(opAddi, 2, 0, 37));    // Low 5 bits give 5
    putInst(encodeR(fnSllv, 3, 1, 2));
    putInst(encodeI(opAddi, 4, 0, -1));
    putInst(encodeI(opAddi, 5, 0, 68));    // Low 5 bits give 4
    putInst(encodeR(fnSrlv, 6, 4, 5));
    putInst(encodeR(fnSrlv, 7, 3, 2));
    putInst(encodeI(opAddi, 8, 0, 'h200));
    putInst(encodeI(opSw, 3, 8, 0));
    putInst(encodeI(opSw, 6, 8, 4));
    putInst(encodeI(opSw, 7, 8, 8));
    putInst(encodeI(opAddi, 9, 0, 32));    // Shift by 0
    putInst(encodeR(fnSllv, 10, 1, 9));
    putInst(encodeI(opSw, 10, 8, 12));
    putInst(encodeB(opBeq, 0, 0, -1));
  endtask

  task automatic buildLoadProgram();
    clearProgram();
    putInst(encodeI(opAddi, 1, 0, 'h300));
    putInst(encodeI(opAddi, 2, 0, 77));
    putInst(encodeI(opSw, 2, 1, 0));
    putInst(encodeI(opLw, 3, 1, 0));       // Reads the store just made
    putInst(encodeR(fnAdd, 4, 3, 3));      // Load-use bubble
    putInst(encodeI(opSw, 4, 1, 4));
    putInst(encodeI(opLw, 5, 1, 4));
    putInst(encodeI(opSw, 5, 1, 8));       // Dependent store data
    putInst(encodeI(opLw, 6, 1, 64));      // Fill pattern word
    putInst(encodeI(opAddi, 7, 6, 1));
    putInst(encodeI(opSw, 7, 1, 12));
    putInst(encodeI(opLw, 8, 1, 8));
    putInst(encodeI(opLw, 9, 1, 12));
    putInst(encodeR(fnAdd, 10, 8, 9));
    putInst(encodeI(opSw, 10, 1, 16));
    putInst(encodeB(opBeq, 0, 0, -1));
  endtask

  task automatic buildBranchProgram();
    clearProgram();
    putInst(encodeI(opAddi, 1, 0, 3));     // Loop counter
    putInst(encodeI(opAddi, 2, 0, 0));
    putInst(encodeI(opAddi, 3, 0, 'h380));
    putInst(encodeR(fnAdd, 2, 2, 1));      // Loop head, index 3
    putInst(encodeI(opSw, 2, 3, 0));
    putInst(encodeI(opAddi, 3, 3, 4));
    putInst(encodeI(opAddi, 1, 1, -1));
    putInst(encodeB(opBne, 1, 0, -5));     // Back to index 3
    putInst(encodeB(opBeq, 1, 0, 1));      // Taken, skips next
    putInst(encodeI(opSw, 1, 0, 0));       // Must never appear
    putInst(encodeB(opBeq, 2, 0, 1));      // Not taken
    putInst(encodeI(opSw, 2, 0, 'h3f0));
    putInst(encodeB(opBne, 2, 2, 1));      // Not taken
    putInst(encodeI(opSw, 1, 0, 'h3f4));
    putInst(encodeB(opBeq, 0, 0, -1));
  endtask

  task automatic runTest(input string name, input bit randomStall, input bit checkReset);
    int expCount;
    checking   = 0;
    testName   = name;
    testErrors = 0;
    restart    = 1;
    @(posedge CLK);
    #1;
    restart = 0;
    for (int i = 0; i < 256; i++) dmem[i] = fillWord(i);
    expCount = interpret();
    @(posedge RST_X);  // Rises 1 ns after the last reset edge
    if (checkReset && (D_WE !== 4'b0000 || D_OE !== 1'b0 || I_ADDR !== '0)) begin
      $display("Mismatch test %s: expected D_WE 0 D_OE 0 I_ADDR 0, actual %b %b %h",
               name, D_WE, D_OE, I_ADDR);
      testErrors++;
    end
    seen       = 0;
    checking   = 1;
    cycleLimit = activeCycles + 3 * expCount + 100;
    while (seen < expAddr.size()) begin
      @(posedge CLK);
      #1;
      STALL = randomStall ? ({$random(seed)} % 3 == 0) : 1'b0;  // About a third
    end
    repeat (20) begin
      @(posedge CLK);
      #1;
      STALL = 1'b0;
    end
    checking = 0;
    if (testErrors == 0) begin
      passCount++;
      $display("test %s: ok, %0d stores", name, seen);
    end else begin
      failCount++;
      $display("test %s: failed with %0d errors", name, testErrors);
    end
  endtask

  initial begin
    STALL        = 1'b0;
    restart      = 1'b0;
    D_IN         = '0;
    checking     = 0;
    seen         = 0;
    testErrors   = 0;
    passCount    = 0;
    failCount    = 0;
    activeCycles = 0;
    cycleLimit   = 1000;  // Covers setup before the first test
    testName     = "setup";
    clearProgram();
    putInst(encodeB(opBeq, 0, 0, -1));
    runTest("reset", 1'b0, 1'b1);
    buildForwardProgram();
    runTest("forwarding", 1'b0, 1'b0);
    buildShiftProgram();
    runTest("shifts", 1'b0, 1'b0);
    buildLoadProgram();
    runTest("load-use", 1'b0, 1'b0);
    buildBranchProgram();
    runTest("branches", 1'b0, 1'b0);
    runTest("random stall", 1'b1, 1'b0);  // Same branch program
    $display("tests passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/tbClock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbClock #(
  parameter int ResetCycles = 4
) (
  input  wire  restart,  // Request a fresh reset pulse
  output logic CLK,
  output logic RST_X
);

  int   lowLeft = ResetCycles - 1;  // Edges still to hold reset low
  logic restartSeen;

  initial begin
    CLK   = 1'b0;
    RST_X = 1'b0;
  end

  always #5 CLK = ~CLK;  // 10 ns period

  always begin
    @(posedge CLK);
    restartSeen = restart;  // Sampled at the edge
    #1;
    if (restartSeen) lowLeft = ResetCycles;
    if (lowLeft > 0) begin
      RST_X = 1'b0;
      lowLeft--;
    end else begin
      RST_X = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mipsCore.sv ====
`timescale 1ns/100ps
`default_nettype none

module mipsCore #(
  parameter int AddrWidth = 11
) (
  input  wire                  CLK,
  input  wire                  RST_X,
  input  wire                  STALL,        // Freezes the whole pipeline
  output wire [AddrWidth-1:0]  I_ADDR,
  input  wire mipsPkg::wordT   I_IN,         // Same-cycle instruction read
  output wire mipsPkg::wordT   D_ADDR,
  input  wire mipsPkg::wordT   D_IN,
  output wire mipsPkg::wordT   D_OUT,
  output wire                  D_OE,
  output wire [3:0]            D_WE
);
  import mipsPkg::*;

  wire [AddrWidth-1:0] ifPc;
  wire [AddrWidth-1:0] ifPc4;
  wire wordT           ifInst;
  wire regIdxT         rsIdx;
  wire regIdxT         rtIdx;
  wire wordT           rsVal;
  wire wordT           rtVal;
  wire idExT           idEx;
  wire [AddrWidth-1:0] branchTarget;
  wire                 hazardStall;
  wire regIdxT         exLoadDest;
  wire exMemT          exMem;
  wire                 redirect;
  wire [AddrWidth-1:0] redirectPc;
  wire regIdxT         memLoadDest;
  wire regWriteT       wbWrite;      // WB result, also the EX bypass

  fetchStage #(.AddrWidth(AddrWidth)) fetchStage_inst (
    .CLK(CLK), .RST_X(RST_X), .STALL(STALL), .hazardStall(hazardStall),
    .redirect(redirect), .redirectPc(redirectPc), .I_IN(I_IN), .I_ADDR(I_ADDR),
    .ifPc(ifPc), .ifPc4(ifPc4), .ifInst(ifInst)
  );

  decodeStage #(.AddrWidth(AddrWidth)) decodeStage_inst (
    .CLK(CLK), .RST_X(RST_X), .STALL(STALL), .redirect(redirect),
    .ifPc(ifPc), .ifPc4(ifPc4), .ifInst(ifInst), .exLoadDest(exLoadDest),
    .rsVal(rsVal), .rtVal(rtVal), .rsIdx(rsIdx), .rtIdx(rtIdx), .idEx(idEx),
    .branchTarget(branchTarget), .hazardStall(hazardStall)
  );

  regFile regFile_inst (
    .CLK(CLK), .rsIdx(rsIdx), .rtIdx(rtIdx), .wbWrite(wbWrite), .STALL(STALL),
    .rsVal(rsVal), .rtVal(rtVal)
  );

  executeStage #(.AddrWidth(AddrWidth)) executeStage_inst (
    .CLK(CLK), .RST_X(RST_X), .STALL(STALL), .idEx(idEx), .branchTarget(branchTarget),
    .wbWrite(wbWrite), .memLoadDest(memLoadDest), .exLoadDest(exLoadDest),
    .exMem(exMem), .redirect(redirect), .redirectPc(redirectPc)
  );

  memWbStage memWbStage_inst (
    .CLK(CLK), .RST_X(RST_X), .STALL(STALL), .exMem(exMem), .D_IN(D_IN),
    .D_ADDR(D_ADDR), .D_OUT(D_OUT), .D_OE(D_OE), .D_WE(D_WE),
    .memLoadDest(memLoadDest), .wbWrite(wbWrite)
  );

endmodule

`default_nettype wire

// ==== hdl/memWbStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module memWbStage (
  input  wire                  CLK,
  input  wire                  RST_X,
  input  wire                  STALL,
  input  wire mipsPkg::exMemT  exMem,
  input  wire mipsPkg::wordT   D_IN,         // Valid the cycle after D_OE
  output mipsPkg::wordT        D_ADDR,
  output mipsPkg::wordT        D_OUT,
  output logic                 D_OE,
  output logic [3:0]           D_WE,
  output mipsPkg::regIdxT      memLoadDest,
  output mipsPkg::regWriteT    wbWrite
);
  import mipsPkg::*;

  regIdxT wbDest;
  wordT   wbResult;
  logic   wbIsLoad;   // Take data from D_IN

  assign D_ADDR      = exMem.result;
  assign D_OUT       = exMem.storeData;
  assign D_OE        = !STALL && (exMem.op == aluLw);  // Held slot strobes once
  assign D_WE        = (!STALL && exMem.op == aluSw) ? 4'b1111 : 4'b0000;
  assign memLoadDest = (exMem.op == aluLw) ? exMem.dest : '0;

  // MEM/WB
  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      wbDest   <= '0;
      wbIsLoad <= 1'b0;
    end else if (!STALL) begin
      wbDest   <= exMem.dest;
      wbIsLoad <= (exMem.op == aluLw);
      wbResult <= exMem.result;
    end
  end

  assign wbWrite = regWriteT'{dest: wbDest, data: wbIsLoad ? D_IN : wbResult};

  assert property (@(posedge CLK) disable iff (!RST_X) D_OE |-> (D_WE == 4'b0000))
    else $error("memWbStage: read and write strobes together");

endmodule

`default_nettype wire

// ==== hdl/executeStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module executeStage #(
  parameter int AddrWidth = 11
) (
  input  wire                    CLK,
  input  wire                    RST_X,
  input  wire                    STALL,
  input  wire mipsPkg::idExT     idEx,
  input  wire [AddrWidth-1:0]    branchTarget,
  input  wire mipsPkg::regWriteT wbWrite,       // Bypass from WB
  input  wire mipsPkg::regIdxT   memLoadDest,   // Load in MEM, value not ready yet
  output mipsPkg::regIdxT        exLoadDest,
  output mipsPkg::exMemT         exMem,
  output logic                   redirect,
  output logic [AddrWidth-1:0]   redirectPc
);
  import mipsPkg::*;

  wordT opA;        // rs after forwarding
  wordT rtFwd;      // rt after forwarding, compare and store data
  wordT opB;        // Second ALU operand
  wordT aluResult;
  logic isBranch;
  logic taken;
  logic redirectQ;  // Redirect seen last cycle

  // Youngest producer wins, EX/MEM before WB
  function automatic wordT forward(input regIdxT src, input wordT regVal,
                                   input exMemT mem, input regIdxT memLoad,
                                   input regWriteT wb);
    wordT val;
    if (src != '0 && mem.dest == src && memLoad != src) begin
      val = mem.result;
    end else if (src != '0 && wb.dest == src) begin
      val = wb.data;
    end else begin
      val = regVal;
    end
    return val;
  endfunction

  assign opA   = forward(idEx.rs, idEx.rsVal, exMem, memLoadDest, wbWrite);
  assign rtFwd = forward(idEx.rt, idEx.rtVal, exMem, memLoadDest, wbWrite);
  assign opB   = idEx.useImm ? idEx.imm : rtFwd;

  always_comb begin
    case (idEx.op)
      aluSllv:              aluResult = opA << opB[4:0];  // Only low 5 bits shift
      aluSrlv:              aluResult = opA >> opB[4:0];  // Logical, zero fill
      aluAdd, aluLw, aluSw: aluResult = opA + opB;
      default:              aluResult = '0;
    endcase
  end

  // Not-taken is assumed, only a taken branch redirects
  assign isBranch   = (idEx.op == aluBeq) || (idEx.op == aluBne);
  assign taken      = (idEx.op == aluBne) ? (opA != rtFwd) : (opA == rtFwd);
  assign redirect   = isBranch && taken && !redirectQ;
  assign redirectPc = branchTarget;
  assign exLoadDest = (idEx.op == aluLw) ? idEx.dest : '0;

  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      redirectQ <= 1'b0;
    end else if (!STALL) begin
      redirectQ <= redirect;
    end
  end

  // EX/MEM
  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      exMem.op   <= aluNop;
      exMem.dest <= '0;
    end else if (!STALL) begin
      exMem.op        <= redirectQ ? aluNop : idEx.op;
      exMem.dest      <= redirectQ ? '0 : idEx.dest;  // Flushed slot
      exMem.result    <= aluResult;
      exMem.storeData <= rtFwd;
    end
  end

  // Decode only hands over branch ops on a redirect path
  assert property (@(posedge CLK) disable iff (!RST_X)
                   redirect |-> (idEx.op inside {aluBeq, aluBne}))
    else $error("executeStage: redirect from a non-branch op");

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/100ps
`default_nettype none

module regFile (
  input  wire                    CLK,
  input  wire mipsPkg::regIdxT   rsIdx,
  input  wire mipsPkg::regIdxT   rtIdx,
  input  wire mipsPkg::regWriteT wbWrite,  // dest 0 means no write
  input  wire                    STALL,
  output mipsPkg::wordT          rsVal,
  output mipsPkg::wordT          rtVal
);
  import mipsPkg::*;

  wordT regs [0:31];  // Entry 0 never written nor read
  logic writeEn;

  assign writeEn = (wbWrite.dest != '0) && !STALL;

  always_ff @(posedge CLK) begin
    if (writeEn) begin
      regs[wbWrite.dest] <= wbWrite.data;
    end
  end

  // r0 reads 0, same-cycle write passes straight through
  assign rsVal = (rsIdx == '0)           ? '0 :
                 (rsIdx == wbWrite.dest) ? wbWrite.data : regs[rsIdx];
  assign rtVal = (rtIdx == '0)           ? '0 :
                 (rtIdx == wbWrite.dest) ? wbWrite.data : regs[rtIdx];

endmodule

`default_nettype wire

// ==== hdl/decodeStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decodeStage #(
  parameter int AddrWidth = 11
) (
  input  wire                    CLK,
  input  wire                    RST_X,
  input  wire                    STALL,
  input  wire                    redirect,     // Flush the slot going to EX
  input  wire [AddrWidth-1:0]    ifPc,
  input  wire [AddrWidth-1:0]    ifPc4,
  input  wire mipsPkg::wordT     ifInst,
  input  wire mipsPkg::regIdxT   exLoadDest,   // Load sitting in EX, 0 if none
  input  wire mipsPkg::wordT     rsVal,
  input  wire mipsPkg::wordT     rtVal,
  output mipsPkg::regIdxT        rsIdx,
  output mipsPkg::regIdxT        rtIdx,
  output mipsPkg::idExT          idEx,
  output logic [AddrWidth-1:0]   branchTarget,
  output logic                   hazardStall
);
  import mipsPkg::*;

  regIdxT               rdIdx;
  wordT                 immExt;
  aluOpE                decOp;
  regIdxT               decDest;
  logic                 decUseImm;
  logic                 readsRs;       // Instruction really uses rs
  logic                 readsRt;
  logic                 bubble;
  logic [AddrWidth-1:0] branchOffset;

  assign rsIdx        = ifInst[25:21];
  assign rtIdx        = ifInst[20:16];
  assign rdIdx        = ifInst[15:11];
  assign immExt       = {{16{ifInst[15]}}, ifInst[15:0]};
  assign branchOffset = {immExt[AddrWidth-3:0], 2'b00};  // Word offset to bytes

  always_comb begin
    decOp     = aluNop;
    decDest   = '0;
    decUseImm = 1'b0;
    readsRs   = 1'b0;
    readsRt   = 1'b0;
    case (ifInst[31:26])
      opSpecial: begin
        case (ifInst[5:0])
          fnAdd:   decOp = aluAdd;
          fnSllv:  decOp = aluSllv;
          fnSrlv:  decOp = aluSrlv;
          default: decOp = aluNop;   // Includes the all-zero word
        endcase
        if (decOp != aluNop) begin
          decDest = rdIdx;
          readsRs = 1'b1;
          readsRt = 1'b1;
        end
      end
      opAddi: begin
        decOp     = aluAdd;
        decDest   = rtIdx;  // I-format writes rt
        decUseImm = 1'b1;
        readsRs   = 1'b1;
      end
      opLw: begin
        decOp     = aluLw;
        decDest   = rtIdx;
        decUseImm = 1'b1;
        readsRs   = 1'b1;
      end
      opSw: begin
        decOp     = aluSw;
        decUseImm = 1'b1;   // rt is store data, not an ALU input
        readsRs   = 1'b1;
        readsRt   = 1'b1;
      end
      opBeq, opBne: begin
        decOp   = (ifInst[31:26] == opBeq) ? aluBeq : aluBne;
        readsRs = 1'b1;
        readsRt = 1'b1;
      end
      default: decOp = aluNop;
    endcase
  end

  // Loaded value only exists after MEM, so wait one cycle
  assign hazardStall = (exLoadDest != '0) &&
                       ((readsRs && exLoadDest == rsIdx) || (readsRt && exLoadDest == rtIdx));
  assign bubble      = redirect || hazardStall;

  // ID/EX
  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      idEx.op   <= aluNop;
      idEx.dest <= '0;
    end else if (!STALL) begin
      idEx.op     <= bubble ? aluNop : decOp;
      idEx.dest   <= bubble ? '0 : decDest;
      idEx.rs     <= rsIdx;
      idEx.rt     <= rtIdx;
      idEx.rsVal  <= rsVal;        // Includes write-through from WB
      idEx.rtVal  <= rtVal;
      idEx.imm    <= immExt;
      idEx.useImm <= decUseImm;
      branchTarget <= ifPc4 + branchOffset;
    end
  end

  assert property (@(posedge CLK) disable iff (!RST_X) (idEx.op == aluNop) |-> (idEx.dest == '0))
    else $error("decodeStage: bubble carries a destination");

endmodule

`default_nettype wire

// ==== hdl/fetchStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetchStage #(
  parameter int AddrWidth = 11
) (
  input  wire                  CLK,
  input  wire                  RST_X,
  input  wire                  STALL,
  input  wire                  hazardStall,  // Load-use hold from ID
  input  wire                  redirect,     // Taken branch in EX
  input  wire [AddrWidth-1:0]  redirectPc,
  input  wire mipsPkg::wordT   I_IN,
  output logic [AddrWidth-1:0] I_ADDR,
  output logic [AddrWidth-1:0] ifPc,
  output logic [AddrWidth-1:0] ifPc4,
  output mipsPkg::wordT        ifInst
);

  logic [AddrWidth-1:0] pc;       // Address on the instruction port
  logic [AddrWidth-1:0] pcPlus4;
  logic                 advance;  // Sequential fetch moves on
  logic                 takeJump; // Redirect wins over a load-use hold

  assign I_ADDR   = pc;
  assign pcPlus4  = pc + AddrWidth'(4);
  assign advance  = !STALL && !hazardStall;
  assign takeJump = !STALL && redirect;

  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      pc <= '0;
    end else if (takeJump) begin
      pc <= redirectPc;   // Target is on I_ADDR next cycle
    end else if (advance) begin
      pc <= pcPlus4;
    end
  end

  // IF/ID, instruction word is the control part
  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      ifInst <= '0;
    end else if (takeJump) begin
      ifInst <= '0;       // Squash wrong-path fetch, decodes as no-op
    end else if (advance) begin
      ifInst <= I_IN;
    end
  end

  always_ff @(posedge CLK) begin
    if (takeJump || advance) begin
      ifPc  <= pc;
      ifPc4 <= pcPlus4;
    end
  end

  // Branch targets from ID must keep the PC on word boundaries
  assert property (@(posedge CLK) disable iff (!RST_X) pc[1:0] == 2'b00)
    else $error("fetchStage: PC not word aligned");

endmodule

`default_nettype wire

// ==== hdl/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

  // Primary opcode field, inst[31:26]
  typedef enum logic [5:0] {
    opSpecial = 6'h00,  // R-format, operation in funct
    opBeq     = 6'h04,
    opBne     = 6'h05,
    opAddi    = 6'h08,
    opLw      = 6'h23,
    opSw      = 6'h2b
  } opcodeE;

  // Funct field of R-format, inst[5:0]
  typedef enum logic [5:0] {
    fnSllv = 6'h04,
    fnSrlv = 6'h06,
    fnAdd  = 6'h20
  } functE;

  // What EX does with the slot
  typedef enum logic [2:0] {
    aluNop,   // Bubble or unknown encoding
    aluAdd,   // ADD and ADDI
    aluSllv,
    aluSrlv,
    aluBeq,
    aluBne,
    aluLw,    // Address calc, load in MEM
    aluSw     // Address calc, store in MEM
  } aluOpE;

  typedef logic [4:0]  regIdxT;
  typedef logic [31:0] wordT;

  typedef struct packed {
    aluOpE  op;
    regIdxT rs;
    regIdxT rt;
    regIdxT dest;    // Zero when nothing is written
    wordT   rsVal;
    wordT   rtVal;
    wordT   imm;     // Sign-extended
    logic   useImm;  // Second operand is imm
  } idExT;

  typedef struct packed {
    aluOpE  op;
    regIdxT dest;
    wordT   result;     // ALU value or memory address
    wordT   storeData;
  } exMemT;

  // Writeback bus, dest 0 means no write
  typedef struct packed {
    regIdxT dest;
    wordT   data;
  } regWriteT;

endpackage

`default_nettype wire
